// File: hw/serial_link_pkg.sv
package serial_link_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Link dimensions
  ////////////////////////////////////////////////////////////////////////////

  localparam int NUM_CHANNELS = 4;
  localparam int NUM_LANES    = 2;
  localparam int PAYLOAD_W    = 32;

  // Each channel carries an equal slice of every payload
  localparam int FLIT_W           = PAYLOAD_W / NUM_CHANNELS;
  localparam int SYMBOLS_PER_FLIT = FLIT_W / NUM_LANES;

  // Receive buffer depth and the credits granted after reset
  localparam int RX_DEPTH = 2;
  localparam int CREDIT_W = $clog2(RX_DEPTH + 1);

  ////////////////////////////////////////////////////////////////////////////
  // Data types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [PAYLOAD_W-1:0] payload_t;
  typedef logic [FLIT_W-1:0]    flit_t;
  typedef logic [NUM_LANES-1:0] symbol_t;

  // Channel 0 sits in the low bits
  typedef flit_t [NUM_CHANNELS-1:0] flit_bus_t;

  // Wires of one physical channel
  typedef struct packed {
    logic    sym_valid;
    symbol_t sym;
  } lane_bus_t;

  ////////////////////////////////////////////////////////////////////////////
  // State machines
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic {
    IDLE,
    SHIFT
  } tx_state_e;

endpackage

// File: hw/link_tx_splitter.sv
module link_tx_splitter (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,
  // Payload stream from the source
  input  serial_link_pkg::payload_t                payload_i,
  input  logic                                     in_valid_i,
  output logic                                     in_ready_o,
  // Credit return from the remote receiver
  input  logic                                     credit_i,
  // Towards the physical channels
  input  logic [serial_link_pkg::NUM_CHANNELS-1:0] tx_ready_i,
  output logic                                     tx_valid_o,
  output serial_link_pkg::flit_bus_t               tx_flits_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Flow control
  ////////////////////////////////////////////////////////////////////////////

  // One credit per free flit slot in the remote receive buffers
  logic [serial_link_pkg::CREDIT_W-1:0] credits_q;
  logic                                 have_credit;
  logic                                 all_ready;
  logic                                 accept;

  assign have_credit = (credits_q != '0);
  assign all_ready   = &tx_ready_i;

  // Every channel must take its flit in the same cycle
  assign in_ready_o = have_credit && all_ready;
  assign accept     = in_valid_i && in_ready_o;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      credits_q <= serial_link_pkg::RX_DEPTH[serial_link_pkg::CREDIT_W-1:0];
    end else begin
      // A returning credit cancels the one spent in the same cycle
      if (accept && !credit_i) begin
        credits_q <= credits_q - 1'b1;
      end else if (credit_i && !accept) begin
        credits_q <= credits_q + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Payload slicing
  ////////////////////////////////////////////////////////////////////////////

  // Channels load their flit at the accepting edge
  assign tx_valid_o = accept;

  always_comb begin
    for (int c = 0; c < serial_link_pkg::NUM_CHANNELS; c++) begin
      tx_flits_o[c] = payload_i[c*serial_link_pkg::FLIT_W +: serial_link_pkg::FLIT_W];
    end
  end

endmodule

// File: hw/link_phy_channel.sv
module link_phy_channel (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  // Transmit side
  input  logic                           tx_valid_i,
  input  serial_link_pkg::flit_t         tx_flit_i,
  output logic                           tx_ready_o,
  output serial_link_pkg::lane_bus_t     lane_o,
  // Receive side
  input  serial_link_pkg::lane_bus_t     lane_i,
  input  logic                           rx_pop_i,
  output logic                           rx_valid_o,
  output serial_link_pkg::flit_t         rx_flit_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Serializer
  ////////////////////////////////////////////////////////////////////////////

  serial_link_pkg::tx_state_e                         tx_state_q;
  serial_link_pkg::flit_t                             tx_shreg_q;
  logic [$clog2(serial_link_pkg::SYMBOLS_PER_FLIT)-1:0] tx_cnt_q;
  logic                                               tx_load;

  assign tx_ready_o = (tx_state_q == serial_link_pkg::IDLE);
  assign tx_load    = tx_ready_o && tx_valid_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      tx_state_q <= serial_link_pkg::IDLE;
      tx_cnt_q   <= '0;
    end else begin
      case (tx_state_q)
        serial_link_pkg::IDLE: begin
          if (tx_valid_i) begin
            tx_state_q <= serial_link_pkg::SHIFT;
            tx_cnt_q   <= '0;
          end
        end
        serial_link_pkg::SHIFT: begin
          // Last symbol goes out this cycle
          if (int'(tx_cnt_q) == serial_link_pkg::SYMBOLS_PER_FLIT - 1) begin
            tx_state_q <= serial_link_pkg::IDLE;
          end
          tx_cnt_q <= tx_cnt_q + 1'b1;
        end
        default: tx_state_q <= serial_link_pkg::IDLE;
      endcase
    end
  end

  // LSB symbol first
  always_ff @(posedge clk_i) begin
    if (tx_load) begin
      tx_shreg_q <= tx_flit_i;
    end else if (tx_state_q == serial_link_pkg::SHIFT) begin
      tx_shreg_q <= tx_shreg_q >> serial_link_pkg::NUM_LANES;
    end
  end

  assign lane_o.sym_valid = (tx_state_q == serial_link_pkg::SHIFT);
  assign lane_o.sym       = tx_shreg_q[serial_link_pkg::NUM_LANES-1:0];

  ////////////////////////////////////////////////////////////////////////////
  // Deserializer
  ////////////////////////////////////////////////////////////////////////////

  // Lanes are captured in a flop before the shift register
  serial_link_pkg::lane_bus_t                         rx_lane_q;
  serial_link_pkg::flit_t                             rx_shreg_q;
  serial_link_pkg::flit_t                             rx_flit_next;
  logic [$clog2(serial_link_pkg::SYMBOLS_PER_FLIT)-1:0] rx_cnt_q;
  logic                                               rx_wr;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rx_lane_q <= '0;
      rx_cnt_q  <= '0;
    end else begin
      rx_lane_q <= lane_i;
      if (rx_lane_q.sym_valid) begin
        rx_cnt_q <= rx_cnt_q + 1'b1;
      end
    end
  end

  // New symbols enter at the top and move down
  assign rx_flit_next = {rx_lane_q.sym,
                         rx_shreg_q[serial_link_pkg::FLIT_W-1:serial_link_pkg::NUM_LANES]};
  assign rx_wr = rx_lane_q.sym_valid &&
                 (int'(rx_cnt_q) == serial_link_pkg::SYMBOLS_PER_FLIT - 1);

  always_ff @(posedge clk_i) begin
    if (rx_lane_q.sym_valid) begin
      rx_shreg_q <= rx_flit_next;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Receive buffer
  ////////////////////////////////////////////////////////////////////////////

  serial_link_pkg::flit_t                   rx_mem_q [serial_link_pkg::RX_DEPTH];
  logic [$clog2(serial_link_pkg::RX_DEPTH)-1:0] rx_wr_ptr_q;
  logic [$clog2(serial_link_pkg::RX_DEPTH)-1:0] rx_rd_ptr_q;
  logic [serial_link_pkg::CREDIT_W-1:0]     rx_count_q;
  logic                                     rx_rd;

  assign rx_valid_o = (rx_count_q != '0);
  assign rx_flit_o  = rx_mem_q[rx_rd_ptr_q];
  assign rx_rd      = rx_pop_i && rx_valid_o;

  // Credits keep the writer from ever finding the buffer full
  always_ff @(posedge clk_i) begin
    if (rx_wr) begin
      rx_mem_q[rx_wr_ptr_q] <= rx_flit_next;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rx_wr_ptr_q <= '0;
      rx_rd_ptr_q <= '0;
      rx_count_q  <= '0;
    end else begin
      if (rx_wr) begin
        if (int'(rx_wr_ptr_q) == serial_link_pkg::RX_DEPTH - 1) rx_wr_ptr_q <= '0;
        else rx_wr_ptr_q <= rx_wr_ptr_q + 1'b1;
      end
      if (rx_rd) begin
        if (int'(rx_rd_ptr_q) == serial_link_pkg::RX_DEPTH - 1) rx_rd_ptr_q <= '0;
        else rx_rd_ptr_q <= rx_rd_ptr_q + 1'b1;
      end
      case ({rx_wr, rx_rd})
        2'b10:   rx_count_q <= rx_count_q + 1'b1;
        2'b01:   rx_count_q <= rx_count_q - 1'b1;
        default: rx_count_q <= rx_count_q;
      endcase
    end
  end

endmodule

// File: hw/link_rx_merger.sv
module link_rx_merger (
  input  logic                                     clk_i,
  input  logic                                     rst_n_i,
  // From the physical channels
  input  logic [serial_link_pkg::NUM_CHANNELS-1:0] rx_valid_i,
  input  serial_link_pkg::flit_bus_t               rx_flits_i,
  output logic                                     rx_pop_o,
  // Rebuilt payload stream
  output logic                                     out_valid_o,
  input  logic                                     out_ready_i,
  output serial_link_pkg::payload_t                out_payload_o,
  // Credit back to the remote sender
  output logic                                     credit_o
);

  ////////////////////////////////////////////////////////////////////////////
  // Payload rebuild
  ////////////////////////////////////////////////////////////////////////////

  logic transfer;

  // A payload exists only once every channel holds its flit
  assign out_valid_o = &rx_valid_i;
  assign transfer    = out_valid_o && out_ready_i;

  always_comb begin
    for (int c = 0; c < serial_link_pkg::NUM_CHANNELS; c++) begin
      out_payload_o[c*serial_link_pkg::FLIT_W +: serial_link_pkg::FLIT_W] = rx_flits_i[c];
    end
  end

  // All heads leave together
  assign rx_pop_o = transfer;

  ////////////////////////////////////////////////////////////////////////////
  // Credit return
  ////////////////////////////////////////////////////////////////////////////

  logic credit_q;

  // Pulse one cycle after the pop frees a slot in every channel
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      credit_q <= 1'b0;
    end else begin
      credit_q <= transfer;
    end
  end

  assign credit_o = credit_q;

endmodule

// File: hw/serial_link.sv
module serial_link (
  input  logic                                                     clk_i,
  input  logic                                                     rst_n_i,
  // Payload input stream
  input  serial_link_pkg::payload_t                                payload_i,
  input  logic                                                     in_valid_i,
  output logic                                                     in_ready_o,
  input  logic                                                     credit_i,
  // Off-chip lanes
  input  serial_link_pkg::lane_bus_t [serial_link_pkg::NUM_CHANNELS-1:0] lane_i,
  output serial_link_pkg::lane_bus_t [serial_link_pkg::NUM_CHANNELS-1:0] lane_o,
  // Payload output stream
  output logic                                                     out_valid_o,
  input  logic                                                     out_ready_i,
  output serial_link_pkg::payload_t                                out_payload_o,
  output logic                                                     credit_o
);

  logic                                     tx_valid;
  serial_link_pkg::flit_bus_t               tx_flits;
  logic [serial_link_pkg::NUM_CHANNELS-1:0] tx_ready;

  logic [serial_link_pkg::NUM_CHANNELS-1:0] rx_valid;
  serial_link_pkg::flit_bus_t               rx_flits;
  logic                                     rx_pop;

  ////////////////////////////////////////////////////////////////////////////
  // Transmit splitter
  ////////////////////////////////////////////////////////////////////////////

  link_tx_splitter i_link_tx_splitter (
    .clk_i      ( clk_i      ),
    .rst_n_i    ( rst_n_i    ),
    .payload_i  ( payload_i  ),
    .in_valid_i ( in_valid_i ),
    .in_ready_o ( in_ready_o ),
    .credit_i   ( credit_i   ),
    .tx_ready_i ( tx_ready   ),
    .tx_valid_o ( tx_valid   ),
    .tx_flits_o ( tx_flits   )
  );

  ////////////////////////////////////////////////////////////////////////////
  // Physical channels
  ////////////////////////////////////////////////////////////////////////////

  for (genvar c = 0; c < serial_link_pkg::NUM_CHANNELS; c++) begin : gen_channels
    link_phy_channel i_link_phy_channel (
      .clk_i      ( clk_i       ),
      .rst_n_i    ( rst_n_i     ),
      .tx_valid_i ( tx_valid    ),
      .tx_flit_i  ( tx_flits[c] ),
      .tx_ready_o ( tx_ready[c] ),
      .lane_o     ( lane_o[c]   ),
      .lane_i     ( lane_i[c]   ),
      .rx_pop_i   ( rx_pop      ),
      .rx_valid_o ( rx_valid[c] ),
      .rx_flit_o  ( rx_flits[c] )
    );
  end

  ////////////////////////////////////////////////////////////////////////////
  // Receive merger
  ////////////////////////////////////////////////////////////////////////////

  link_rx_merger i_link_rx_merger (
    .clk_i         ( clk_i         ),
    .rst_n_i       ( rst_n_i       ),
    .rx_valid_i    ( rx_valid      ),
    .rx_flits_i    ( rx_flits      ),
    .rx_pop_o      ( rx_pop        ),
    .out_valid_o   ( out_valid_o   ),
    .out_ready_i   ( out_ready_i   ),
    .out_payload_o ( out_payload_o ),
    .credit_o      ( credit_o      )
  );

endmodule

// File: testbench/link_checker.sv
module link_checker (
  input  logic                                                           clk_i,
  input  logic                                                           rst_n_i,
  // Input stream of the link
  input  serial_link_pkg::payload_t                                      payload_i,
  input  logic                                                           in_valid_i,
  input  logic                                                           in_ready_i,
  // Lanes as driven by the transmitter
  input  serial_link_pkg::lane_bus_t [serial_link_pkg::NUM_CHANNELS-1:0] lane_i,
  // Output stream and credit return
  input  logic                                                           out_valid_i,
  input  logic                                                           out_ready_i,
  input  serial_link_pkg::payload_t                                      out_payload_i,
  input  logic                                                           credit_i,
  // End of run
  input  logic                                                           done_i,
  input  int                                                             expected_beats_i,
  output int                                                             pending_o,
  output int                                                             mismatch_count_o,
  output int                                                             failure_count_o
);

  // Edges from acceptance to out_valid on an empty link
  localparam int IDLE_LATENCY = 5;

  serial_link_pkg::payload_t model_q [$];
  int   accepted, returned, received;
  int   busy, lat_edges, lat_checks, stalls;
  int   mismatches, failures;
  logic lat_active, credit_due, reset_seen, audited;

  assign pending_o        = accepted - received;
  assign mismatch_count_o = mismatches;
  assign failure_count_o  = failures;

  task automatic log_mismatch(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
    $display("Mismatch in %s: expected %0h, actual %0h", name, exp, act);
    mismatches++;
  endtask

  task automatic note_failure(input string msg);
    $display("Error: %s", msg);
    failures++;
  endtask

  task automatic verify_reset_state();
    logic [serial_link_pkg::NUM_CHANNELS-1:0] sym_valids;
    for (int c = 0; c < serial_link_pkg::NUM_CHANNELS; c++) begin
      sym_valids[c] = lane_i[c].sym_valid;
    end
    if (in_ready_i !== 1'b1) log_mismatch("reset in_ready", 32'(1), 32'(in_ready_i));
    if (out_valid_i !== 1'b0) log_mismatch("reset out_valid", 32'(0), 32'(out_valid_i));
    if (credit_i !== 1'b0) log_mismatch("reset credit", 32'(0), 32'(credit_i));
    if (sym_valids !== '0) log_mismatch("reset sym_valid", 32'(0), 32'(sym_valids));
  endtask

  task automatic audit_end();
    if (accepted != received) begin
      note_failure($sformatf("%0d beats never left the link", accepted - received));
    end
    if (received != expected_beats_i) begin
      note_failure($sformatf("%0d beats delivered, %0d expected", received, expected_beats_i));
    end
    if (lat_checks == 0) note_failure("no beat entered an idle link, latency never measured");
    if (stalls == 0) note_failure("credits never ran out, back-pressure not exercised");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Monitor sampled between rising edges
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin : watch
    logic                      exp_ready;
    logic                      xfer;
    int                        credits;
    serial_link_pkg::payload_t exp;
    if (!rst_n_i) begin
      model_q.delete();
      accepted   = 0;
      returned   = 0;
      received   = 0;
      busy       = 0;
      lat_active = 1'b0;
      credit_due = 1'b0;
      reset_seen = 1'b0;
      audited    = 1'b0;
    end else begin
      if (!reset_seen) begin
        verify_reset_state();
        reset_seen = 1'b1;
      end
      credits = serial_link_pkg::RX_DEPTH - (accepted - returned);
      if (credits == 0 && in_valid_i) stalls++;

      // Each output transfer returns one credit pulse a cycle later
      if (credit_i !== credit_due) log_mismatch("credit_return", 32'(credit_due), 32'(credit_i));

      // Ready needs a credit and serializers done with the last flit
      exp_ready = (credits > 0) && (busy == 0);
      if (in_ready_i !== exp_ready) log_mismatch("in_ready", 32'(exp_ready), 32'(in_ready_i));
      if (busy > 0) busy--;

      if (lat_active) begin
        lat_edges++;
        if (out_valid_i || lat_edges > IDLE_LATENCY) begin
          if (lat_edges != IDLE_LATENCY) log_mismatch("idle_latency", IDLE_LATENCY, lat_edges);
          lat_active = 1'b0;
          lat_checks++;
        end
      end

      xfer = out_valid_i && out_ready_i;
      if (xfer) begin
        if (model_q.size() == 0) begin
          note_failure("payload left the link with no beat outstanding");
        end else begin
          exp = model_q.pop_front();
          if (out_payload_i !== exp) log_mismatch("data", exp, out_payload_i);
          received++;
        end
      end
      credit_due = xfer;

      if (in_valid_i && in_ready_i) begin
        // Empty model means an idle data path
        if (model_q.size() == 0) begin
          lat_active = 1'b1;
          lat_edges  = -1;
        end
        model_q.push_back(payload_i);
        accepted++;
        busy = serial_link_pkg::SYMBOLS_PER_FLIT;
      end
      if (credit_i) returned++;
      if (accepted - returned > serial_link_pkg::RX_DEPTH) begin
        note_failure("more beats outstanding than receive buffer slots");
      end

      if (done_i && !audited) begin
        audit_end();
        audited = 1'b1;
      end
    end
  end

endmodule

// File: testbench/tb_serial_link.sv
module tb_serial_link;

  localparam int          NUM_BEATS      = 300;
  localparam logic [31:0] SEED           = 32'h5504_52b6;
  localparam int          TIMEOUT_CYCLES = NUM_BEATS * 20 + 100;
  localparam int          HOLD_CYCLES    = 20;
  // Idle beat, the back-pressure burst and the beat stalled behind it
  localparam int          TOTAL_BEATS    = NUM_BEATS + serial_link_pkg::RX_DEPTH + 2;

  logic                                                           clk = 1'b0;
  logic                                                           rst_n;
  serial_link_pkg::payload_t                                      in_payload;
  logic                                                           in_valid;
  logic                                                           in_ready;
  logic                                                           credit;
  serial_link_pkg::lane_bus_t [serial_link_pkg::NUM_CHANNELS-1:0] lanes;
  logic                                                           out_valid;
  logic                                                           out_ready;
  serial_link_pkg::payload_t                                      out_payload;
  logic                                                           done;
  int                                                             pending;
  int                                                             mismatch_count;
  int                                                             failure_count;
  logic [31:0]                                                    rand_state;

  always #5 clk = ~clk;

  // Lanes and credits looped back onto the same link
  serial_link UUT (
    .clk_i         ( clk         ),
    .rst_n_i       ( rst_n       ),
    .payload_i     ( in_payload  ),
    .in_valid_i    ( in_valid    ),
    .in_ready_o    ( in_ready    ),
    .credit_i      ( credit      ),
    .lane_i        ( lanes       ),
    .lane_o        ( lanes       ),
    .out_valid_o   ( out_valid   ),
    .out_ready_i   ( out_ready   ),
    .out_payload_o ( out_payload ),
    .credit_o      ( credit      )
  );

  link_checker u_link_checker (
    .clk_i            ( clk            ),
    .rst_n_i          ( rst_n          ),
    .payload_i        ( in_payload     ),
    .in_valid_i       ( in_valid       ),
    .in_ready_i       ( in_ready       ),
    .lane_i           ( lanes          ),
    .out_valid_i      ( out_valid      ),
    .out_ready_i      ( out_ready      ),
    .out_payload_i    ( out_payload    ),
    .credit_i         ( credit         ),
    .done_i           ( done           ),
    .expected_beats_i ( TOTAL_BEATS    ),
    .pending_o        ( pending        ),
    .mismatch_count_o ( mismatch_count ),
    .failure_count_o  ( failure_count  )
  );

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  // Returns 1 unit after the edge that took the beat
  task automatic wait_accept();
    logic taken;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = in_ready;
      @(posedge clk);
      #1;
    end
  endtask

  task automatic send_beat(input serial_link_pkg::payload_t p);
    in_payload = p;
    in_valid   = 1'b1;
    wait_accept();
    in_valid = 1'b0;
  endtask

  task automatic wait_drained();
    @(posedge clk);
    while (pending != 0) @(posedge clk);
    #1;
  endtask

  task automatic run_idle_latency();
    out_ready = 1'b1;
    send_beat(next_rand());
    wait_drained();
  endtask

  task automatic run_backpressure();
    out_ready = 1'b0;
    repeat (serial_link_pkg::RX_DEPTH) send_beat(next_rand());
    // This one must wait for a returned credit
    in_payload = next_rand();
    in_valid   = 1'b1;
    repeat (HOLD_CYCLES) @(posedge clk);
    #1;
    out_ready = 1'b1;
    wait_accept();
    in_valid = 1'b0;
    wait_drained();
  endtask

  task automatic run_random(input int n);
    int   sent;
    logic hs;
    sent = 0;
    while (sent < n) begin
      @(negedge clk);
      hs = in_valid && in_ready;
      @(posedge clk);
      #1;
      if (hs) begin
        in_valid = 1'b0;
        sent++;
      end
      // A presented beat stays until taken
      if (!in_valid && sent < n && next_rand() >= 32'h4000_0000) begin
        in_payload = next_rand();
        in_valid   = 1'b1;
      end
      out_ready = (next_rand() >= 32'h4000_0000);
    end
  endtask

  initial begin
    rst_n      = 1'b0;
    in_payload = '0;
    in_valid   = 1'b0;
    out_ready  = 1'b1;
    done       = 1'b0;
    rand_state = SEED;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    run_idle_latency();
    run_backpressure();
    run_random(NUM_BEATS);
    out_ready = 1'b1;
    wait_drained();

    done = 1'b1;
    @(posedge clk);
    $display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
    if (mismatch_count == 0 && failure_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Error: run did not finish within %0d cycles, %0d beats outstanding",
             TIMEOUT_CYCLES, pending);
    $display("Errors: %0d mismatches, %0d other failures", mismatch_count, failure_count + 1);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: vlog.f
hw/serial_link_pkg.sv
hw/link_tx_splitter.sv
hw/link_phy_channel.sv
hw/link_rx_merger.sv
hw/serial_link.sv
testbench/link_checker.sv
testbench/tb_serial_link.sv

// File: Makefile
VERILATOR  ?= verilator
TOP        ?= tb_serial_link
RTL_TOP    ?= serial_link
FILELIST   ?= vlog.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only -Wall
RTL_SRCS   ?= $(filter hw/%,$(shell cat $(FILELIST)))
PASS_MSG   ?= ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)
